// File: src.f
source/fifo_pkg.sv
source/fifo_push_ctrl.sv
source/fifo_pop_ctrl.sv
source/fifo_ctrl_1r1w.sv
source/fifo_ram_1r1w.sv
source/fifo_top.sv
testbench/fifo_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Builds the FIFO testbench with Verilator, runs it and checks the log

set -u
cd "$(dirname "$0")" || exit 1

log_file=sim.log

verilator --binary --timing --assert -Wno-fatal \
  -f src.f --top-module fifo_tb -o fifo_tb_sim
status=$?
if [ "$status" -ne 0 ]; then
  echo "run.sh: Verilator build failed with status $status"
  exit 1
fi

./obj_dir/fifo_tb_sim > "$log_file" 2>&1
status=$?
cat "$log_file"
if [ "$status" -ne 0 ]; then
  echo "run.sh: simulation exited with status $status"
  exit 1
fi

if grep -qx "Verification passed" "$log_file"; then
  echo "run.sh: pass message found in $log_file"
  exit 0
else
  echo "run.sh: pass message missing from $log_file"
  exit 1
fi

// File: testbench/fifo_tb.sv
`timescale 1ns/1ps
// Random ready/valid testbench for fifo_top with bypass enabled (the default)
// Inputs change 10 ns after a rising edge and outputs are compared at the edge
// The queue model holds exactly the items that the FIFO has stored

module fifo_tb;
  import fifo_pkg::*;

  // ----------------------------------------------------------------------
  // Run length and timing budget
  // ----------------------------------------------------------------------

  localparam int     reset_cycles      = 3;
  localparam int     directed_cycles   = 4 * fifo_depth + 16;
  localparam int     transfer_goal     = 2000;
  localparam int     max_random_cycles = 12000;
  localparam int     phase_cycles      = 150;
  localparam int     test_cycles       = reset_cycles + 2 * directed_cycles + max_random_cycles;
  localparam longint watchdog_ns       = longint'(test_cycles) * 100 + 5000;

  // Expected port values for one cycle, derived from the model queue
  typedef struct packed {
    logic                   push_ready;
    logic                   pop_valid;
    logic [data_width-1:0]  pop_data;
    logic [count_width-1:0] count;
    logic [count_width-1:0] count_next;
  } expect_t;

  logic                  clk;
  logic                  arst_n;
  logic                  push_valid;
  logic [data_width-1:0] push_data;
  logic                  push_ready;
  logic                  pop_ready;
  logic                  pop_valid;
  logic [data_width-1:0] pop_data;
  push_status_t          push_status;
  pop_status_t           pop_status;

  logic [data_width-1:0] model_q[$];
  logic [31:0]           lcg_state = 32'h8304;
  logic [7:0]            item_seq  = 8'h00;
  bit                    push_fired;
  bit                    checking;
  int                    pops_seen;

  fifo_top i_dut (
    .clk         (clk),
    .arst_n      (arst_n),
    .push_valid  (push_valid),
    .push_data   (push_data),
    .push_ready  (push_ready),
    .pop_ready   (pop_ready),
    .pop_valid   (pop_valid),
    .pop_data    (pop_data),
    .push_status (push_status),
    .pop_status  (pop_status)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // ----------------------------------------------------------------------
  // Helpers
  // ----------------------------------------------------------------------

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  // Advances the generator and returns a value from 0 to 99
  function automatic int unsigned roll_percent();
    lcg_state = lcg_next(lcg_state);
    return int'(lcg_state[31:16]) % 100;
  endfunction

  task automatic stop_with_failure(input string reason);
    $display("%s", reason);
    $display("Verification failed");
    $fatal(1, "run stopped");
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      stop_with_failure($sformatf("[FAIL] %s: actual 0x%0h, expected 0x%0h",
                                  name, actual, expected));
    end
  endtask

  // Front of the FIFO, push acceptance and counts before and after this cycle
  // An empty FIFO shows the offered push itself, which is the bypass rule
  function automatic expect_t ref_expect(input logic pv, input logic [data_width-1:0] pd,
                                         input logic pr);
    expect_t e;
    logic    push_fire;
    logic    pop_fire;
    e.count      = count_width'(model_q.size());
    e.push_ready = (model_q.size() < fifo_depth);
    if (model_q.size() != 0) begin
      e.pop_valid = 1'b1;
      e.pop_data  = model_q[0];
    end else begin
      e.pop_valid = pv;
      e.pop_data  = pd;
    end
    push_fire    = pv && e.push_ready;
    pop_fire     = e.pop_valid && pr;
    e.count_next = e.count + count_width'(push_fire) - count_width'(pop_fire);
    return e;
  endfunction

  // Waits for the next edge, notes whether the push was taken, then moves
  // to the drive point
  task automatic step();
    @(posedge clk);
    push_fired = push_valid && push_ready;
    #10;
  endtask

  // A stalled push is held; new data is made only after a transfer
  task automatic drive_inputs(input bit want_push, input bit want_pop);
    if (!(push_valid && !push_fired)) begin
      if (push_fired) begin
        lcg_state = lcg_next(lcg_state);
        item_seq  = item_seq + 8'd1;
        push_data = {lcg_state[23:16], item_seq};
      end
      push_valid = want_push;
    end
    pop_ready = want_pop;
  endtask

  task automatic drain_fifo();
    int cycles;
    cycles = 0;
    do begin
      drive_inputs(1'b0, 1'b1);
      step();
      cycles++;
    end while ((!pop_status.empty || push_valid) && cycles < directed_cycles);
    if (!pop_status.empty || push_valid) begin
      stop_with_failure("The FIFO did not drain with pop_ready held high");
    end
    check_value("model count", model_q.size(), 0);
  endtask

  // ----------------------------------------------------------------------
  // Compare process
  // ----------------------------------------------------------------------

  initial begin : compare_proc
    expect_t e;
    forever begin
      @(posedge clk);
      if (checking) begin
        e = ref_expect(push_valid, push_data, pop_ready);
        check_value("push_ready", push_ready, e.push_ready);
        check_value("full", push_status.full, e.count == fifo_depth);
        check_value("full_next", push_status.full_next, e.count_next == fifo_depth);
        check_value("slots", push_status.slots, fifo_depth - e.count);
        check_value("slots_next", push_status.slots_next, fifo_depth - e.count_next);
        check_value("items", pop_status.items, e.count);
        check_value("items_next", pop_status.items_next, e.count_next);
        check_value("empty", pop_status.empty, e.count == 0);
        check_value("empty_next", pop_status.empty_next, e.count_next == 0);
        check_value("pop_valid", pop_valid, e.pop_valid);
        if (e.pop_valid) begin
          check_value("pop_data", pop_data, e.pop_data);
        end
        // Zero-cycle cut-through on an empty FIFO
        if (pop_status.empty && push_valid) begin
          check_value("bypass pop_valid", pop_valid, 1);
          check_value("bypass pop_data", pop_data, push_data);
        end
        // Push goes in before pop comes out, so a bypass leaves the queue empty
        if (push_valid && e.push_ready) begin
          model_q.push_back(push_data);
        end
        if (e.pop_valid && pop_ready) begin
          void'(model_q.pop_front());
          pops_seen++;
        end
      end
    end
  end

  initial begin
    #(watchdog_ns);
    $display("The watchdog expired before the tests finished");
    $display("Verification failed");
    $fatal(1, "timeout");
  end

  // ----------------------------------------------------------------------
  // Main sequence
  // ----------------------------------------------------------------------

  initial begin : main_proc
    int cycles;
    int phase;
    arst_n     = 1'b0;
    push_valid = 1'b0;
    push_data  = 16'h0001;
    pop_ready  = 1'b0;
    push_fired = 1'b0;
    checking   = 1'b0;
    repeat (reset_cycles) @(posedge clk);
    #10;
    arst_n = 1'b1;
    #1;
    check_value("push_ready", push_ready, 1);
    check_value("full", push_status.full, 0);
    check_value("slots", push_status.slots, fifo_depth);
    check_value("empty", pop_status.empty, 1);
    check_value("items", pop_status.items, 0);
    check_value("pop_valid", pop_valid, 0);
    checking = 1'b1;

    // Fill with the consumer stalled until push_ready drops
    cycles = 0;
    do begin
      drive_inputs(1'b1, 1'b0);
      step();
      cycles++;
    end while (push_ready && cycles <= fifo_depth + 2);
    if (push_ready) begin
      stop_with_failure("push_ready never dropped while the consumer was stalled");
    end
    check_value("model count", model_q.size(), fifo_depth);
    // Offers while full must be refused
    repeat (2) begin
      drive_inputs(1'b1, 1'b0);
      step();
    end
    // A single pop frees a slot by the next cycle
    drive_inputs(1'b1, 1'b1);
    step();
    check_value("push_ready", push_ready, 1);
    drain_fifo();

    // Random traffic in alternating heavy-push and heavy-pop phases
    cycles = 0;
    while (pops_seen < transfer_goal && cycles < max_random_cycles) begin
      phase = (cycles / phase_cycles) % 2;
      if (phase == 0) begin
        drive_inputs(roll_percent() < 85, roll_percent() < 35);
      end else begin
        drive_inputs(roll_percent() < 35, roll_percent() < 85);
      end
      step();
      cycles++;
    end
    drain_fifo();

    if (pops_seen < transfer_goal) begin
      stop_with_failure("Too few transfers completed in the random phases");
    end else begin
      $display("Verification passed");
      $finish;
    end
  end

endmodule

// File: source/fifo_top.sv
`timescale 1ns/1ps
// FIFO top level with ready/valid on both sides and a flop-based RAM
// With enable_bypass set, an empty FIFO passes a push to the pop side at once
// There is no flush input, and only reset empties the FIFO

module fifo_top #(
  parameter bit enable_bypass = 1'b1
) (
  input  logic                            clk,
  input  logic                            arst_n,
  input  logic                            push_valid,
  input  logic [fifo_pkg::data_width-1:0] push_data,
  output logic                            push_ready,
  input  logic                            pop_ready,
  output logic                            pop_valid,
  output logic [fifo_pkg::data_width-1:0] pop_data,
  output fifo_pkg::push_status_t          push_status,
  output fifo_pkg::pop_status_t           pop_status
);
  import fifo_pkg::*;

  // RAM port between the controller and the array
  ram_wr_t               ram_wr;
  ram_rd_t               ram_rd;
  logic [data_width-1:0] ram_rd_data;
  logic                  ram_rd_data_valid;

  fifo_ctrl_1r1w #(
    .enable_bypass(enable_bypass)
  ) i_ctrl (
    .clk               (clk),
    .arst_n            (arst_n),
    .push_valid        (push_valid),
    .push_data         (push_data),
    .push_ready        (push_ready),
    .pop_ready         (pop_ready),
    .pop_valid         (pop_valid),
    .pop_data          (pop_data),
    .push_status       (push_status),
    .pop_status        (pop_status),
    .ram_wr            (ram_wr),
    .ram_rd            (ram_rd),
    .ram_rd_data       (ram_rd_data),
    .ram_rd_data_valid (ram_rd_data_valid)
  );

  fifo_ram_1r1w i_ram (
    .clk               (clk),
    .arst_n            (arst_n),
    .ram_wr            (ram_wr),
    .ram_rd            (ram_rd),
    .ram_rd_data       (ram_rd_data),
    .ram_rd_data_valid (ram_rd_data_valid)
  );

endmodule

// File: source/fifo_ram_1r1w.sv
`timescale 1ns/1ps
// Flop-array RAM with one write port and one read port
// A write takes effect on the next rising edge and a read is combinational
// The array contents are undefined after reset

module fifo_ram_1r1w (
  input  logic                            clk,
  input  logic                            arst_n,
  input  fifo_pkg::ram_wr_t               ram_wr,
  input  fifo_pkg::ram_rd_t               ram_rd,
  output logic [fifo_pkg::data_width-1:0] ram_rd_data,
  output logic                            ram_rd_data_valid
);
  import fifo_pkg::*;

  logic [data_width-1:0] mem [fifo_depth];
  logic                  wr_en;

  // Writes are held off while reset is applied
  assign wr_en = arst_n && ram_wr.valid;

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[ram_wr.addr] <= ram_wr.data;
    end
  end

  // ----------------------------------------------------------------------
  // Read port
  // ----------------------------------------------------------------------

  // Read data comes straight from the array in the cycle it is addressed
  assign ram_rd_data       = mem[ram_rd.addr];
  assign ram_rd_data_valid = ram_rd.addr_valid;

endmodule

// File: source/fifo_ctrl_1r1w.sv
`timescale 1ns/1ps
// FIFO controller for one write and one read RAM port, holding no storage
// RAM writes land on the next edge and RAM reads return in the same cycle
// The push source must hold valid and data stable while it is stalled

module fifo_ctrl_1r1w #(
  parameter bit enable_bypass = 1'b1
) (
  input  logic                            clk,
  input  logic                            arst_n,
  input  logic                            push_valid,
  input  logic [fifo_pkg::data_width-1:0] push_data,
  output logic                            push_ready,
  input  logic                            pop_ready,
  output logic                            pop_valid,
  output logic [fifo_pkg::data_width-1:0] pop_data,
  output fifo_pkg::push_status_t          push_status,
  output fifo_pkg::pop_status_t           pop_status,
  output fifo_pkg::ram_wr_t               ram_wr,
  output fifo_pkg::ram_rd_t               ram_rd,
  input  logic [fifo_pkg::data_width-1:0] ram_rd_data,
  input  logic                            ram_rd_data_valid
);
  import fifo_pkg::*;

  logic                  bypass_valid;
  logic                  bypass_ready;
  logic [data_width-1:0] bypass_data;
  logic                  ram_push;
  logic                  ram_pop;

  fifo_push_ctrl #(
    .enable_bypass(enable_bypass)
  ) i_push_ctrl (
    .clk          (clk),
    .arst_n       (arst_n),
    .push_valid   (push_valid),
    .push_data    (push_data),
    .push_ready   (push_ready),
    .push_status  (push_status),
    .bypass_valid (bypass_valid),
    .bypass_data  (bypass_data),
    .bypass_ready (bypass_ready),
    .ram_wr       (ram_wr),
    .ram_push     (ram_push),
    .ram_pop      (ram_pop)
  );

  fifo_pop_ctrl #(
    .enable_bypass(enable_bypass)
  ) i_pop_ctrl (
    .clk               (clk),
    .arst_n            (arst_n),
    .pop_ready         (pop_ready),
    .pop_valid         (pop_valid),
    .pop_data          (pop_data),
    .pop_status        (pop_status),
    .bypass_valid      (bypass_valid),
    .bypass_data       (bypass_data),
    .bypass_ready      (bypass_ready),
    .ram_rd            (ram_rd),
    .ram_rd_data       (ram_rd_data),
    .ram_rd_data_valid (ram_rd_data_valid),
    .ram_push          (ram_push),
    .ram_pop           (ram_pop)
  );

  // ----------------------------------------------------------------------
  // Integration checks
  // ----------------------------------------------------------------------

  // A stalled push keeps its valid and data until it is accepted
  push_backpressure_a: assert property (@(posedge clk) disable iff (!arst_n)
    push_valid && !push_ready |=> push_valid && $stable(push_data));

  // ----------------------------------------------------------------------
  // Implementation checks
  // ----------------------------------------------------------------------

  // Both sides count the same RAM events, so their counts stay coherent
  items_plus_slots_a: assert property (@(posedge clk) disable iff (!arst_n)
    pop_status.items + push_status.slots == fifo_depth);
  items_next_plus_slots_next_a: assert property (@(posedge clk) disable iff (!arst_n)
    pop_status.items_next + push_status.slots_next == fifo_depth);

  // A write and a read in the same cycle cancel out
  push_and_pop_keep_counts_a: assert property (@(posedge clk) disable iff (!arst_n)
    ram_push && ram_pop |-> pop_status.items_next == pop_status.items &&
                            push_status.slots_next == push_status.slots);

  // One pop while full frees a slot by the next cycle
  backpressure_latency_a: assert property (@(posedge clk) disable iff (!arst_n)
    push_status.full && pop_ready |=> !push_status.full && push_ready);

  if (enable_bypass) begin : gen_bypass_checks
    // An empty FIFO shows a push at the pop port in the same cycle
    cutthrough_0_delay_a: assert property (@(posedge clk) disable iff (!arst_n)
      push_valid && pop_status.empty |-> pop_valid && pop_data == push_data);
  end else begin : gen_no_bypass_checks
    // Without bypass the push goes through the RAM and shows up one cycle later
    cutthrough_1_delay_a: assert property (@(posedge clk) disable iff (!arst_n)
      push_valid && pop_status.empty |=> pop_valid && pop_data == $past(push_data));
  end

endmodule

// File: source/fifo_pop_ctrl.sv
`timescale 1ns/1ps
// Pop side of the FIFO controller, with no storage of its own
// RAM data always wins over the bypass input while the RAM holds items
// The RAM must answer a read in the same cycle as its address

module fifo_pop_ctrl #(
  parameter bit enable_bypass = 1'b1
) (
  input  logic                            clk,
  input  logic                            arst_n,
  input  logic                            pop_ready,
  output logic                            pop_valid,
  output logic [fifo_pkg::data_width-1:0] pop_data,
  output fifo_pkg::pop_status_t           pop_status,
  input  logic                            bypass_valid,
  input  logic [fifo_pkg::data_width-1:0] bypass_data,
  output logic                            bypass_ready,
  output fifo_pkg::ram_rd_t               ram_rd,
  input  logic [fifo_pkg::data_width-1:0] ram_rd_data,
  input  logic                            ram_rd_data_valid,
  input  logic                            ram_push,
  output logic                            ram_pop
);
  import fifo_pkg::*;

  logic                   ram_valid;
  logic [addr_width-1:0]  rd_addr;
  logic [addr_width-1:0]  rd_addr_next;
  logic [count_width-1:0] items;
  logic [count_width-1:0] items_next;
  logic                   empty;
  logic                   empty_next;

  // ----------------------------------------------------------------------
  // RAM read port
  // ----------------------------------------------------------------------

  // The head entry is read whenever the RAM holds anything
  assign ram_rd.addr_valid = !empty;
  assign ram_rd.addr       = rd_addr;

  // Data from the RAM is usable only when the head address was requested
  assign ram_valid = !empty && ram_rd_data_valid;

  // ----------------------------------------------------------------------
  // Pop port and bypass
  // ----------------------------------------------------------------------

  // The bypass is taken only by an empty RAM and a consumer that is ready now
  // If the consumer stalls, the push is stored and shows up again from the RAM
  assign bypass_ready = enable_bypass && empty && pop_ready;

  assign pop_valid = ram_valid || (enable_bypass && bypass_valid);
  assign pop_data  = ram_valid ? ram_rd_data : bypass_data;

  // Only a pop that consumes RAM data frees an entry
  assign ram_pop = ram_valid && pop_ready;

  // ----------------------------------------------------------------------
  // Pointer and item count
  // ----------------------------------------------------------------------

  assign rd_addr_next = (rd_addr == addr_width'(fifo_depth - 1)) ? '0 : rd_addr + 1'b1;

  // Bypassed items never reach this count because they are never stored
  assign items_next = items + count_width'(ram_push) - count_width'(ram_pop);
  assign empty_next = (items_next == '0);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rd_addr <= '0;
      items   <= '0;
      empty   <= 1'b1;
    end else begin
      if (ram_pop) begin
        rd_addr <= rd_addr_next;
      end
      items <= items_next;
      empty <= empty_next;
    end
  end

  assign pop_status.empty      = empty;
  assign pop_status.empty_next = empty_next;
  assign pop_status.items      = items;
  assign pop_status.items_next = items_next;

  // ----------------------------------------------------------------------
  // Checks
  // ----------------------------------------------------------------------

  // The attached RAM has a read latency of zero
  ram_rd_latency_zero_a: assert property (@(posedge clk) disable iff (!arst_n)
    ram_rd.addr_valid |-> ram_rd_data_valid);

  // An offered item stays offered and unchanged until the consumer takes it
  // This holds even when a stalled bypass moves into the RAM underneath
  pop_hold_a: assert property (@(posedge clk) disable iff (!arst_n)
    pop_valid && !pop_ready |=> pop_valid && $stable(pop_data));

endmodule

// File: source/fifo_push_ctrl.sv
`timescale 1ns/1ps
// Push side of the FIFO controller, with no storage of its own
// Every push is offered to the pop side first and goes to the RAM unless taken
// push_ready is a flop output, so nothing combinational runs from pop to push

module fifo_push_ctrl #(
  parameter bit enable_bypass = 1'b1
) (
  input  logic                            clk,
  input  logic                            arst_n,
  input  logic                            push_valid,
  input  logic [fifo_pkg::data_width-1:0] push_data,
  output logic                            push_ready,
  output fifo_pkg::push_status_t          push_status,
  output logic                            bypass_valid,
  output logic [fifo_pkg::data_width-1:0] bypass_data,
  input  logic                            bypass_ready,
  output fifo_pkg::ram_wr_t               ram_wr,
  output logic                            ram_push,
  input  logic                            ram_pop
);
  import fifo_pkg::*;

  logic                   push_beat;
  logic                   bypass_beat;
  logic [addr_width-1:0]  wr_addr;
  logic [addr_width-1:0]  wr_addr_next;
  logic [count_width-1:0] slots;
  logic [count_width-1:0] slots_next;
  logic                   full;
  logic                   full_next;

  // ----------------------------------------------------------------------
  // Handshake and routing
  // ----------------------------------------------------------------------

  // The FIFO refuses new data only when every slot is taken
  assign push_ready = !full;
  assign push_beat  = push_valid && push_ready;

  // With bypass off the offer is never made, so every push lands in the RAM
  assign bypass_valid = enable_bypass && push_valid;
  assign bypass_data  = push_data;
  assign bypass_beat  = bypass_valid && bypass_ready;

  // An accepted push that the pop side did not take straight away is stored
  assign ram_push = push_beat && !bypass_beat;

  assign ram_wr.valid = ram_push;
  assign ram_wr.addr  = wr_addr;
  assign ram_wr.data  = push_data;

  // ----------------------------------------------------------------------
  // Pointer and slot count
  // ----------------------------------------------------------------------

  // Wrap explicitly so that depths other than a power of two also work
  assign wr_addr_next = (wr_addr == addr_width'(fifo_depth - 1)) ? '0 : wr_addr + 1'b1;

  // One slot is used by a RAM write and one is freed by a RAM read
  assign slots_next = slots + count_width'(ram_pop) - count_width'(ram_push);
  assign full_next  = (slots_next == '0);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_addr <= '0;
      slots   <= count_width'(fifo_depth);
      full    <= 1'b0;
    end else begin
      if (ram_push) begin
        wr_addr <= wr_addr_next;
      end
      slots <= slots_next;
      full  <= full_next;
    end
  end

  assign push_status.full       = full;
  assign push_status.full_next  = full_next;
  assign push_status.slots      = slots;
  assign push_status.slots_next = slots_next;

  // ----------------------------------------------------------------------
  // Checks
  // ----------------------------------------------------------------------

  // A full FIFO must neither accept a push nor overwrite a live RAM entry
  full_blocks_push_a: assert property (@(posedge clk) disable iff (!arst_n)
    full |-> !push_ready && !ram_push);

endmodule

// File: source/fifo_pkg.sv
// Sizes, derived widths and bundled types shared by every FIFO block
// The depth must be at least 2 and need not be a power of two
// Counts are one bit wider than addresses so that a full FIFO can be counted

package fifo_pkg;

  // ----------------------------------------------------------------------
  // Sizes
  // ----------------------------------------------------------------------

  // Number of entries held in the RAM
  localparam int fifo_depth = 8;
  // Width of each stored entry
  localparam int data_width = 16;
  // Address width of the RAM
  localparam int addr_width = $clog2(fifo_depth);
  // Width of an item or slot count, which must reach fifo_depth itself
  localparam int count_width = $clog2(fifo_depth) + 1;

  // ----------------------------------------------------------------------
  // Bundles
  // ----------------------------------------------------------------------

  // Write request to the RAM, taken on the next rising edge
  typedef struct packed {
    logic                  valid;
    logic [addr_width-1:0] addr;
    logic [data_width-1:0] data;
  } ram_wr_t;

  // Read request to the RAM, answered in the same cycle
  typedef struct packed {
    logic                  addr_valid;
    logic [addr_width-1:0] addr;
  } ram_rd_t;

  // Push-side status with registered and look-ahead values
  typedef struct packed {
    logic                   full;
    logic                   full_next;
    logic [count_width-1:0] slots;
    logic [count_width-1:0] slots_next;
  } push_status_t;

  // Pop-side status with registered and look-ahead values
  typedef struct packed {
    logic                   empty;
    logic                   empty_next;
    logic [count_width-1:0] items;
    logic [count_width-1:0] items_next;
  } pop_status_t;

endpackage
